//--- source/cache_defines.svh
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// byte address fields from the msb are tag, set index, word in line and byte select.
`define CACHE_TAG_W      9
`define CACHE_INDEX_W    4
`define CACHE_WORD_W     3

// cache geometry.
`define CACHE_SETS       16
`define CACHE_WAYS       2
`define CACHE_LINE_WORDS 8

// bus widths.
`define SDRAM_ADDR_W     24
`define CPU_ADDR_W       17

`endif

//--- source/cache_pkg.sv
`include "cache_defines.svh"

package cache_pkg;

    // device side request, held by the master until its ack.
    typedef struct packed {
        logic [`CPU_ADDR_W-1:0] addr;
        logic [7:0]             wdata;
        logic                   read;
        logic                   write;
    } cpu_req_t;

    // command to the sdram controller, word addressed.
    typedef struct packed {
        logic [`SDRAM_ADDR_W-1:0] addr;
        logic [15:0]              wdata;
        logic                     read_req;
        logic                     write_req;
    } sdram_cmd_t;

    // one tag store entry per way and set.
    typedef struct packed {
        logic [`CACHE_TAG_W-1:0] tag;
        logic                    valid;
        logic                    dirty;
    } tag_entry_t;

    // registered answer of the tag store to a lookup.
    typedef struct packed {
        logic                    hit;
        logic                    hit_way;
        logic                    victim_way;
        logic                    victim_dirty;
        logic [`CACHE_TAG_W-1:0] victim_tag;
    } lookup_t;

endpackage

//--- source/cache_tag_store.sv
`timescale 1ns/100ps
`include "cache_defines.svh"

module cache_tag_store import cache_pkg::*; (
    input  logic                     sys_clk,
    input  logic                     reset_n,
    input  logic [`CACHE_INDEX_W-1:0] index,
    input  logic                     lookup,
    input  logic [`CACHE_TAG_W-1:0]  req_tag,
    input  logic                     upd_way,
    input  logic                     set_lru,
    input  logic                     set_dirty,
    input  logic                     clear_dirty,
    input  logic                     install,
    output lookup_t                  result
);

    tag_entry_t entry [`CACHE_WAYS][`CACHE_SETS];
    logic [`CACHE_SETS-1:0] lru; // way to replace next, per set.

    tag_entry_t e0;
    tag_entry_t e1;
    logic hit0;
    logic hit1;
    logic victim;

    assign e0 = entry[0][index];
    assign e1 = entry[1][index];

    assign hit0 = e0.valid && (e0.tag == req_tag);
    assign hit1 = e1.valid && (e1.tag == req_tag);

    // a clean way wins over a dirty one; otherwise lru decides.
    always_comb begin
        if (e0.dirty != e1.dirty) begin
            victim = e0.dirty;
        end else begin
            victim = lru[index];
        end
    end

    always_ff @(posedge sys_clk or negedge reset_n) begin
        if (!reset_n) begin
            result <= '0;
        end else if (lookup) begin
            result.hit          <= hit0 | hit1;
            result.hit_way      <= hit1;
            result.victim_way   <= victim;
            result.victim_dirty <= victim ? e1.dirty : e0.dirty;
            result.victim_tag   <= victim ? e1.tag : e0.tag;
        end
    end

    always_ff @(posedge sys_clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                for (int s = 0; s < `CACHE_SETS; s++) begin
                    entry[w][s] <= '0;
                end
            end
            lru <= '0; // way 0 goes first.
        end else begin
            if (set_lru) begin
                lru[index] <= ~upd_way; // the way not touched ages.
            end
            if (install) begin
                entry[upd_way][index] <= '{tag: req_tag, valid: 1'b1, dirty: 1'b0};
            end
            if (set_dirty) begin
                entry[upd_way][index].dirty <= 1'b1;
            end
            if (clear_dirty) begin
                entry[upd_way][index].dirty <= 1'b0;
            end
        end
    end

    // a refill installs clean and the byte write only comes after the re-lookup.
    a_install_not_dirty: assert property (
        @(posedge sys_clk) disable iff (!reset_n) !(install && set_dirty)
    ) else $error("tag store: install and set_dirty in the same cycle");

endmodule

//--- source/cache_data_ram.sv
`timescale 1ns/100ps
`include "cache_defines.svh"

module cache_data_ram #(
    parameter int ADDR_W = `CACHE_INDEX_W + `CACHE_WORD_W
) (
    input  logic              sys_clk,
    input  logic [ADDR_W-1:0] addr,
    input  logic [15:0]       wdata,
    input  logic [1:0]        byte_en,
    input  logic              wr_en,
    output logic [15:0]       rdata
);

    localparam int DEPTH = `CACHE_SETS * `CACHE_LINE_WORDS;

    logic [15:0] mem [DEPTH];

    always_ff @(posedge sys_clk) begin
        if (wr_en) begin
            // per lane write.
            for (int b = 0; b < 2; b++) begin
                if (byte_en[b]) begin
                    mem[addr][b*8 +: 8] <= wdata[b*8 +: 8];
                end
            end
        end
        rdata <= mem[addr]; // old data on a write cycle.
    end

    a_write_has_lane: assert property (
        @(posedge sys_clk) wr_en |-> (byte_en != 2'b00)
    ) else $error("data ram: write with no byte lane enabled");

endmodule

//--- source/cache_ctrl.sv
`timescale 1ns/100ps
`include "cache_defines.svh"

module cache_ctrl import cache_pkg::*; (
    input  logic                                    sys_clk,
    input  logic                                    reset_n,
    input  cpu_req_t                                cpu,
    output logic [7:0]                              rdata,
    output logic                                    read_ack,
    output logic                                    write_ack,
    output sdram_cmd_t                              sdram,
    input  logic [15:0]                             sdram_rdata,
    input  logic                                    sdram_read_ack,
    input  logic                                    sdram_write_ack,
    output logic [`CACHE_INDEX_W-1:0]               index,
    output logic                                    lookup,
    output logic [`CACHE_TAG_W-1:0]                 req_tag,
    output logic                                    upd_way,
    output logic                                    set_lru,
    output logic                                    set_dirty,
    output logic                                    clear_dirty,
    output logic                                    install,
    input  lookup_t                                 result,
    output logic [`CACHE_INDEX_W+`CACHE_WORD_W-1:0] ram_addr,
    output logic [15:0]                             ram_wdata,
    output logic [1:0]                              ram_byte_en,
    output logic                                    wr_en_w0,
    output logic                                    wr_en_w1,
    input  logic [15:0]                             q0,
    input  logic [15:0]                             q1
);

    typedef logic [`CACHE_WORD_W-1:0] word_t;

    localparam int    IDX_LSB   = 1 + `CACHE_WORD_W;
    localparam int    TAG_LSB   = IDX_LSB + `CACHE_INDEX_W;
    localparam int    PAD_W     = `SDRAM_ADDR_W - `CACHE_TAG_W - `CACHE_INDEX_W - `CACHE_WORD_W;
    localparam word_t LAST_WORD = word_t'(`CACHE_LINE_WORDS - 1);

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_COMPARE,
        ST_WRITE_BYTE,
        ST_EVICT_SETUP,
        ST_WRITE_BACK,
        ST_READ_SDRAM,
        ST_FILL,
        ST_FILL_DONE
    } state_t;

    state_t   state;
    cpu_req_t req;         // request latched in idle.
    logic     way_q;       // hit way, or victim way on a miss.
    word_t    word_cnt;    // write-back and fill position.
    logic     sdram_rd;
    logic     sdram_wr;
    logic [`SDRAM_ADDR_W-1:0] sdram_addr;

    logic        new_req;
    logic        byte_sel;
    word_t       req_word;
    word_t       wb_word;
    logic [15:0] hit_word;
    logic        ram_write;
    logic [`SDRAM_ADDR_W-1:0] line_addr;
    logic [`SDRAM_ADDR_W-1:0] victim_addr;

    assign index    = req.addr[TAG_LSB-1:IDX_LSB];
    assign req_tag  = req.addr[TAG_LSB +: `CACHE_TAG_W];
    assign req_word = req.addr[IDX_LSB-1:1];
    assign byte_sel = req.addr[0]; // odd address is the upper byte.

    // ack still high means the master has not dropped its request yet.
    assign new_req = (cpu.read | cpu.write) && !read_ack && !write_ack;

    assign line_addr   = {{PAD_W{1'b0}}, req_tag, index, {`CACHE_WORD_W{1'b0}}};
    assign victim_addr = {{PAD_W{1'b0}}, result.victim_tag, index, {`CACHE_WORD_W{1'b0}}};

    // ram runs one word ahead of the sdram during write-back.
    assign wb_word  = word_cnt + word_t'(sdram_write_ack);
    assign hit_word = result.hit_way ? q1 : q0;

    // tag store control.
    assign lookup      = (state == ST_LOOKUP) || (state == ST_FILL_DONE);
    assign upd_way     = (state == ST_COMPARE) ? result.hit_way : way_q;
    assign set_lru     = (state == ST_COMPARE) && result.hit;
    assign set_dirty   = set_lru && req.write;
    assign clear_dirty = (state == ST_WRITE_BACK) && sdram_write_ack &&
                         (word_cnt == LAST_WORD);
    assign install     = (state == ST_FILL) && (word_cnt == LAST_WORD);

    // optimistic read of the requested word by default.
    always_comb begin
        ram_addr    = {index, req_word};
        ram_wdata   = sdram_rdata;
        ram_byte_en = 2'b11;
        case (state)
            ST_EVICT_SETUP: ram_addr = {index, word_t'(0)};
            ST_WRITE_BACK:  ram_addr = {index, wb_word};
            ST_FILL:        ram_addr = {index, word_cnt};
            ST_WRITE_BYTE: begin
                ram_wdata   = {req.wdata, req.wdata};
                ram_byte_en = byte_sel ? 2'b10 : 2'b01; // merge one lane.
            end
            default: ;
        endcase
    end

    assign ram_write = (state == ST_FILL) || (state == ST_WRITE_BYTE);
    assign wr_en_w0  = ram_write && !way_q;
    assign wr_en_w1  = ram_write && way_q;

    assign sdram = '{
        addr:      sdram_addr,
        wdata:     way_q ? q1 : q0,
        read_req:  sdram_rd,
        write_req: sdram_wr
    };

    always_ff @(posedge sys_clk or negedge reset_n) begin
        if (!reset_n) begin
            state     <= ST_IDLE;
            read_ack  <= 1'b0;
            write_ack <= 1'b0;
            sdram_rd  <= 1'b0;
            sdram_wr  <= 1'b0;
            way_q     <= 1'b0;
            word_cnt  <= '0;
        end else begin
            read_ack  <= 1'b0;
            write_ack <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (new_req) begin
                        state <= ST_LOOKUP;
                    end
                end
                ST_LOOKUP: state <= ST_COMPARE;
                ST_COMPARE: begin
                    if (result.hit) begin
                        way_q <= result.hit_way;
                        if (req.write) begin
                            write_ack <= 1'b1;
                            state     <= ST_WRITE_BYTE;
                        end else begin
                            read_ack <= 1'b1;
                            state    <= ST_IDLE;
                        end
                    end else begin
                        way_q <= result.victim_way;
                        if (result.victim_dirty) begin
                            state <= ST_EVICT_SETUP;
                        end else begin
                            sdram_rd <= 1'b1;
                            state    <= ST_READ_SDRAM;
                        end
                    end
                end
                ST_WRITE_BYTE: state <= ST_IDLE;
                ST_EVICT_SETUP: begin
                    // word 0 of the victim is read this cycle.
                    sdram_wr <= 1'b1;
                    word_cnt <= '0;
                    state    <= ST_WRITE_BACK;
                end
                ST_WRITE_BACK: begin
                    if (sdram_write_ack) begin
                        word_cnt <= word_cnt + 1'b1;
                        if (word_cnt == LAST_WORD) begin
                            sdram_wr <= 1'b0;
                            sdram_rd <= 1'b1;
                            state    <= ST_READ_SDRAM;
                        end
                    end
                end
                ST_READ_SDRAM: begin
                    if (sdram_read_ack) begin
                        sdram_rd <= 1'b0;
                        word_cnt <= '0;
                        state    <= ST_FILL;
                    end
                end
                ST_FILL: begin
                    word_cnt <= word_cnt + 1'b1;
                    if (word_cnt == LAST_WORD) begin
                        state <= ST_FILL_DONE;
                    end
                end
                ST_FILL_DONE: state <= ST_COMPARE; // looks up again, now hits.
                default: state <= ST_IDLE;
            endcase
        end
    end

    // request, read byte and sdram address.
    always_ff @(posedge sys_clk) begin
        if (state == ST_IDLE && new_req) begin
            req <= cpu;
        end
        if (state == ST_COMPARE && result.hit && !req.write) begin
            rdata <= byte_sel ? hit_word[15:8] : hit_word[7:0];
        end
        if (state == ST_COMPARE && !result.hit) begin
            sdram_addr <= result.victim_dirty ? victim_addr : line_addr;
        end
        if (state == ST_WRITE_BACK && sdram_write_ack) begin
            if (word_cnt == LAST_WORD) begin
                sdram_addr <= line_addr;
            end else begin
                sdram_addr <= sdram_addr + 1'b1;
            end
        end
    end

    a_sdram_one_dir: assert property (
        @(posedge sys_clk) disable iff (!reset_n) !(sdram.read_req && sdram.write_req)
    ) else $error("cache ctrl: sdram read and write requested together");

    a_one_ack: assert property (
        @(posedge sys_clk) disable iff (!reset_n) !(read_ack && write_ack)
    ) else $error("cache ctrl: read_ack and write_ack together");

endmodule

//--- source/cache_subsystem.sv
`timescale 1ns/100ps
`include "cache_defines.svh"

module cache_subsystem import cache_pkg::*; (
    input  logic        sys_clk,
    input  logic        reset_n,
    input  cpu_req_t    cpu,
    output logic [7:0]  rdata,
    output logic        read_ack,
    output logic        write_ack,
    output sdram_cmd_t  sdram,
    input  logic [15:0] sdram_rdata,
    input  logic        sdram_read_ack,
    input  logic        sdram_write_ack
);

    // controller to tag store.
    logic [`CACHE_INDEX_W-1:0] index;
    logic                     lookup;
    logic [`CACHE_TAG_W-1:0]  req_tag;
    logic                     upd_way;
    logic                     set_lru;
    logic                     set_dirty;
    logic                     clear_dirty;
    logic                     install;
    lookup_t                  result;

    // controller to both ways of data.
    logic [`CACHE_INDEX_W+`CACHE_WORD_W-1:0] ram_addr;
    logic [15:0] ram_wdata;
    logic [1:0]  ram_byte_en;
    logic        wr_en_w0;
    logic        wr_en_w1;
    logic [15:0] q0;
    logic [15:0] q1;

    cache_ctrl u_ctrl (
        .sys_clk         (sys_clk),
        .reset_n         (reset_n),
        .cpu             (cpu),
        .rdata           (rdata),
        .read_ack        (read_ack),
        .write_ack       (write_ack),
        .sdram           (sdram),
        .sdram_rdata     (sdram_rdata),
        .sdram_read_ack  (sdram_read_ack),
        .sdram_write_ack (sdram_write_ack),
        .index           (index),
        .lookup          (lookup),
        .req_tag         (req_tag),
        .upd_way         (upd_way),
        .set_lru         (set_lru),
        .set_dirty       (set_dirty),
        .clear_dirty     (clear_dirty),
        .install         (install),
        .result          (result),
        .ram_addr        (ram_addr),
        .ram_wdata       (ram_wdata),
        .ram_byte_en     (ram_byte_en),
        .wr_en_w0        (wr_en_w0),
        .wr_en_w1        (wr_en_w1),
        .q0              (q0),
        .q1              (q1)
    );

    cache_tag_store u_tag_store (
        .sys_clk     (sys_clk),
        .reset_n     (reset_n),
        .index       (index),
        .lookup      (lookup),
        .req_tag     (req_tag),
        .upd_way     (upd_way),
        .set_lru     (set_lru),
        .set_dirty   (set_dirty),
        .clear_dirty (clear_dirty),
        .install     (install),
        .result      (result)
    );

    cache_data_ram way0_ram (
        .sys_clk (sys_clk),
        .addr    (ram_addr),
        .wdata   (ram_wdata),
        .byte_en (ram_byte_en),
        .wr_en   (wr_en_w0),
        .rdata   (q0)
    );

    cache_data_ram way1_ram (
        .sys_clk (sys_clk),
        .addr    (ram_addr),
        .wdata   (ram_wdata),
        .byte_en (ram_byte_en),
        .wr_en   (wr_en_w1),
        .rdata   (q1)
    );

endmodule

//--- tb/tb_sdram_model.sv
`timescale 1ns/100ps
`include "cache_defines.svh"

module tb_sdram_model import cache_pkg::*; (
    input  logic        sys_clk,
    input  logic        reset_n,
    input  sdram_cmd_t  cmd,
    output logic [15:0] rdata,
    output logic        read_ack,
    output logic        write_ack
);

    localparam int MEM_WORDS = 1 << 16;

    typedef enum logic [2:0] {
        M_IDLE,
        M_RD_WAIT,
        M_RD_ACK,
        M_RD_BURST,
        M_WR_WAIT,
        M_WR_ACK
    } mstate_t;

    logic [15:0] mem [MEM_WORDS];
    sdram_cmd_t  wr_log [$];  // every accepted write word, in order.
    mstate_t     mstate;
    logic [1:0]  delay;
    logic [3:0]  beat;
    logic [15:0] base;        // line start of the running read burst.
    logic [31:0] lfsr;

    // taps 32, 22, 2, 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_delay(output logic [1:0] d);
        for (int i = 0; i < 2; i++) begin
            lfsr = lfsr_step(lfsr);
            d[i] = lfsr[0];
        end
    endtask

    initial begin
        for (int w = 0; w < MEM_WORDS; w++) begin
            mem[w] = 16'(w * 32'h9e37 + 32'h1234);
        end
    end

    always @(posedge sys_clk or negedge reset_n) begin : respond
        logic [1:0] d;
        if (!reset_n) begin
            mstate    <= M_IDLE;
            read_ack  <= 1'b0;
            write_ack <= 1'b0;
            rdata     <= '0;
            delay     <= '0;
            beat      <= '0;
            base      <= '0;
            lfsr = 32'h3b511b36;
        end else begin
            read_ack  <= 1'b0;
            write_ack <= 1'b0;
            case (mstate)
                M_IDLE: begin
                    if (cmd.read_req || cmd.write_req) begin
                        draw_delay(d);
                        delay  <= d;
                        beat   <= '0;
                        mstate <= cmd.read_req ? M_RD_WAIT : M_WR_WAIT;
                    end
                end
                M_RD_WAIT: begin
                    if (delay == 2'd0) begin
                        read_ack <= 1'b1;
                        base     <= cmd.addr[15:0];
                        mstate   <= M_RD_ACK;
                    end else begin
                        delay <= delay - 1'b1;
                    end
                end
                M_RD_ACK: begin
                    rdata  <= mem[base]; // word 0 in the cycle after the ack.
                    beat   <= 4'd1;
                    mstate <= M_RD_BURST;
                end
                M_RD_BURST: begin
                    if (beat == 4'(`CACHE_LINE_WORDS)) begin
                        mstate <= M_IDLE;
                    end else begin
                        rdata <= mem[base + 16'(beat)];
                        beat  <= beat + 1'b1;
                    end
                end
                M_WR_WAIT: begin
                    if (delay == 2'd0) begin
                        write_ack <= 1'b1;
                        mstate    <= M_WR_ACK;
                    end else begin
                        delay <= delay - 1'b1;
                    end
                end
                M_WR_ACK: begin
                    // the controller still shows the acked word here.
                    mem[cmd.addr[15:0]] <= cmd.wdata;
                    wr_log.push_back(cmd);
                    beat <= beat + 1'b1;
                    if (beat == 4'(`CACHE_LINE_WORDS - 1)) begin
                        mstate <= M_IDLE;
                    end else begin
                        draw_delay(d);
                        delay  <= d;
                        mstate <= M_WR_WAIT;
                    end
                end
                default: mstate <= M_IDLE;
            endcase
        end
    end

endmodule

//--- tb/tb_cache_subsystem.sv
`timescale 1ns/100ps
`include "cache_defines.svh"

module tb_cache_subsystem import cache_pkg::*; ();

    localparam int NUM_OPS        = 23;
    localparam int RESET_CYCLES   = 5;
    localparam int HIT_CYCLES     = 3; // first request cycle to ack cycle.
    localparam int TIMEOUT_CYCLES = NUM_OPS * 60 + RESET_CYCLES;
    localparam int MEM_BYTES      = 1 << `CPU_ADDR_W;

    typedef struct packed {
        logic                    write;
        logic [`CPU_ADDR_W-1:0]  addr;
        logic [7:0]              wdata;
        logic                    fast;   // line resident, ack due in HIT_CYCLES.
        logic                    wb;     // a dirty victim goes out first.
        logic [`CACHE_TAG_W-1:0] wb_tag; // tag of that victim line.
    } op_t;

    // write, byte address, write data, fast, write-back, victim tag.
    localparam op_t OPS [NUM_OPS] = '{
        '{1'b0, 17'h00130, 8'h00, 1'b0, 1'b0, 9'h000},
        '{1'b0, 17'h00131, 8'h00, 1'b1, 1'b0, 9'h000},
        '{1'b0, 17'h00136, 8'h00, 1'b1, 1'b0, 9'h000},
        '{1'b0, 17'h0013f, 8'h00, 1'b1, 1'b0, 9'h000},
        '{1'b0, 17'h00130, 8'h00, 1'b1, 1'b0, 9'h000},
        '{1'b1, 17'h00134, 8'ha5, 1'b1, 1'b0, 9'h000},
        '{1'b0, 17'h00134, 8'h00, 1'b1, 1'b0, 9'h000},
        '{1'b0, 17'h00135, 8'h00, 1'b1, 1'b0, 9'h000},
        '{1'b1, 17'h0a152, 8'h3c, 1'b0, 1'b0, 9'h000},
        '{1'b1, 17'h0a15d, 8'h7e, 1'b1, 1'b0, 9'h000},
        '{1'b1, 17'h0b253, 8'hc1, 1'b0, 1'b0, 9'h000},
        '{1'b0, 17'h0a152, 8'h00, 1'b1, 1'b0, 9'h000},
        '{1'b0, 17'h0c350, 8'h00, 1'b0, 1'b1, 9'h0b2},
        '{1'b0, 17'h0b253, 8'h00, 1'b0, 1'b0, 9'h000},
        '{1'b1, 17'h0b254, 8'h99, 1'b1, 1'b0, 9'h000},
        '{1'b0, 17'h0c35f, 8'h00, 1'b0, 1'b1, 9'h0a1},
        '{1'b0, 17'h0a15d, 8'h00, 1'b0, 1'b0, 9'h000},
        '{1'b0, 17'h0a152, 8'h00, 1'b1, 1'b0, 9'h000},
        '{1'b0, 17'h0b254, 8'h00, 1'b1, 1'b0, 9'h000},
        '{1'b0, 17'h1fff1, 8'h00, 1'b0, 1'b0, 9'h000},
        '{1'b1, 17'h1fffe, 8'h5a, 1'b1, 1'b0, 9'h000},
        '{1'b0, 17'h1fffe, 8'h00, 1'b1, 1'b0, 9'h000},
        '{1'b0, 17'h1ffff, 8'h00, 1'b1, 1'b0, 9'h000}
    };

    logic        sys_clk = 1'b0;
    logic        reset_n;
    cpu_req_t    cpu_req;
    logic [7:0]  rdata;
    logic        read_ack;
    logic        write_ack;
    sdram_cmd_t  sdram;
    logic [15:0] sdram_rdata;
    logic        sdram_read_ack;
    logic        sdram_write_ack;
    logic [7:0]  shadow [MEM_BYTES]; // expected contents, byte addressed.
    int          cycle_cnt = 0;

    always #20 sys_clk = ~sys_clk;

    cache_subsystem DUT (
        .sys_clk         (sys_clk),
        .reset_n         (reset_n),
        .cpu             (cpu_req),
        .rdata           (rdata),
        .read_ack        (read_ack),
        .write_ack       (write_ack),
        .sdram           (sdram),
        .sdram_rdata     (sdram_rdata),
        .sdram_read_ack  (sdram_read_ack),
        .sdram_write_ack (sdram_write_ack)
    );

    tb_sdram_model sdram_model (
        .sys_clk   (sys_clk),
        .reset_n   (reset_n),
        .cmd       (sdram),
        .rdata     (sdram_rdata),
        .read_ack  (sdram_read_ack),
        .write_ack (sdram_write_ack)
    );

    function automatic logic [15:0] init_word(input logic [15:0] w);
        return 16'(32'(w) * 32'h9e37 + 32'h1234);
    endfunction

    function automatic logic [15:0] shadow_word(input logic [15:0] w);
        return {shadow[{w, 1'b1}], shadow[{w, 1'b0}]}; // odd byte is the upper lane.
    endfunction

    task automatic fill_shadow();
        logic [15:0] w;
        for (int a = 0; a < MEM_BYTES; a++) begin
            w = init_word(16'(a >> 1));
            shadow[a] = a[0] ? w[15:8] : w[7:0];
        end
    endtask

    task automatic report_failure(input string msg);
        $display("FAILED at %0t ns: %s", $time, msg);
        $display("Result: FAILED");
        $fatal(1, "check failed");
    endtask

    task automatic check_ack(input logic [`CPU_ADDR_W-1:0] addr, input logic got_read,
                             input logic got_write, input logic is_write);
        if (got_read === is_write || got_write !== is_write) begin
            report_failure($sformatf("wrong ack kind for access to %05h", addr));
        end
    endtask

    task automatic check_byte(input logic [`CPU_ADDR_W-1:0] addr, input logic [7:0] got);
        if (got !== shadow[addr]) begin
            report_failure($sformatf("read of %05h gave %02h, expected %02h",
                                     addr, got, shadow[addr]));
        end
    endtask

    task automatic check_latency(input logic [`CPU_ADDR_W-1:0] addr, input int got);
        if (got != HIT_CYCLES) begin
            report_failure($sformatf("hit on %05h acked after %0d cycles, expected %0d",
                                     addr, got, HIT_CYCLES));
        end
    endtask

    task automatic check_writeback(input sdram_cmd_t got,
                                   input logic [`SDRAM_ADDR_W-1:0] exp_addr);
        logic [15:0] exp_word;
        exp_word = shadow_word(exp_addr[15:0]);
        if (got.addr !== exp_addr || got.wdata !== exp_word) begin
            report_failure($sformatf("write-back %06h:%04h, expected %06h:%04h",
                                     got.addr, got.wdata, exp_addr, exp_word));
        end
    endtask

    task automatic run_op(input op_t op);
        int log_start;
        int cycles;
        int new_words;
        logic [`SDRAM_ADDR_W-1:0] line;
        log_start = sdram_model.wr_log.size();
        cycles    = 0;
        @(posedge sys_clk);
        cpu_req <= '{addr: op.addr, wdata: op.wdata, read: !op.write, write: op.write};
        @(negedge sys_clk);
        while (!(read_ack || write_ack)) begin
            cycles++;
            @(negedge sys_clk);
        end
        check_ack(op.addr, read_ack, write_ack, op.write);
        if (!op.write) begin
            check_byte(op.addr, rdata);
        end
        if (op.fast) begin
            check_latency(op.addr, cycles);
        end
        new_words = sdram_model.wr_log.size() - log_start;
        if (op.wb) begin
            if (new_words != `CACHE_LINE_WORDS) begin
                report_failure($sformatf("expected a full line written back, saw %0d words",
                                         new_words));
            end
            line = `SDRAM_ADDR_W'({op.wb_tag, op.addr[7:4], 3'b000});
            for (int k = 0; k < `CACHE_LINE_WORDS; k++) begin
                check_writeback(sdram_model.wr_log[log_start + k], line + `SDRAM_ADDR_W'(k));
            end
        end else if (new_words != 0) begin
            report_failure($sformatf("unexpected write-back during access to %05h", op.addr));
        end
        if (op.write) begin
            shadow[op.addr] = op.wdata;
        end
        @(posedge sys_clk);
        cpu_req.read  <= 1'b0; // master drops its request after the ack.
        cpu_req.write <= 1'b0;
    endtask

    always @(posedge sys_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Result: FAILED");
            $fatal(1, "simulation timed out");
        end
    end

    initial begin
        reset_n = 1'b0;
        cpu_req = '0;
        fill_shadow();
        repeat (RESET_CYCLES) @(posedge sys_clk);
        reset_n <= 1'b1;
        for (int i = 0; i < NUM_OPS; i++) begin
            run_op(OPS[i]);
        end
        repeat (2) @(posedge sys_clk);
        $display("Result: PASSED");
        $finish;
    end

endmodule

//--- cache_subsystem.f
+incdir+source
source/cache_pkg.sv
source/cache_tag_store.sv
source/cache_data_ram.sv
source/cache_ctrl.sv
source/cache_subsystem.sv
tb/tb_sdram_model.sv
tb/tb_cache_subsystem.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_cache_subsystem
RTL_TOP   ?= cache_subsystem
FILELIST  ?= cache_subsystem.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
JOBS      ?= 0

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(BUILD_DIR)

sim: build
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "^Result: PASSED$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
